// File: filelist.f
+incdir+rtl
rtl/ec_time_pkg.sv
rtl/req_ack_if.sv
rtl/lap_divider.sv
rtl/lap_scaler.sv
rtl/ec_time_to_sys_time.sv
rtl/ec_time_converter_top.sv
verification/ec_time_converter_tb.sv

// File: verification/ec_time_converter_tb.sv
`timescale 1ns/100ps

module ec_time_converter_tb;
  import ec_time_pkg::*;

  localparam longint timeout_ns = 40 * 200 * 100; // 40 conversions of 200 cycles

  logic CLK;
  logic rst_n;
  logic ec_req;
  logic ec_ack;
  ec_time_t ec_time;
  logic sys_req;
  logic sys_ack;
  sys_time_t sys_time;
  logic [31:0] lfsr_q;

  ec_time_converter_top u_ec_time_converter_top (
    .CLK(CLK),
    .rst_n(rst_n),
    .ec_req(ec_req),
    .ec_ack(ec_ack),
    .ec_time(ec_time),
    .sys_req(sys_req),
    .sys_ack(sys_ack),
    .sys_time(sys_time)
  );

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  // Reference rule of 320 system units per whole lap of 31250 ticks
  function automatic sys_time_t expected_sys_time(input ec_time_t t);
    logic [63:0] laps;
    laps = t / 64'd31250;
    return sys_time_t'(laps * 64'd320);
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q); // One step per bit
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  task automatic check_sys_time(input sys_time_t got, input sys_time_t exp, input string msg);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "System time mismatch");
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Handshake level mismatch");
    end
  endtask

  // Upstream four-phase handshake with ec_req held extra cycles after ec_ack
  task automatic send_ec_time(input ec_time_t t, input int hold);
    check_level(ec_ack, 1'b0, "ec_ack low before request");
    ec_time = t;
    ec_req = 1'b1;
    @(negedge CLK);
    while (!ec_ack) @(negedge CLK);
    repeat (hold) begin
      @(negedge CLK);
      check_level(ec_ack, 1'b1, "ec_ack held while ec_req high");
    end
    ec_req = 1'b0;
    ec_time = ~t; // Must already be latched
    @(negedge CLK);
    check_level(ec_ack, 1'b0, "ec_ack released after ec_req falls");
  endtask

  // Downstream four-phase with sys_ack delayed by the given cycles
  task automatic take_sys_time(input int delay, output sys_time_t got);
    while (!sys_req) @(negedge CLK);
    got = sys_time;
    repeat (delay) begin
      @(negedge CLK);
      check_level(sys_req, 1'b1, "sys_req held until sys_ack");
      check_sys_time(sys_time, got, "sys_time stable while sys_req high");
    end
    sys_ack = 1'b1;
    @(negedge CLK);
    check_level(sys_req, 1'b0, "sys_req released after sys_ack");
    sys_ack = 1'b0;
    @(negedge CLK);
    check_level(sys_req, 1'b0, "sys_req stays low after sys_ack falls");
  endtask

  task automatic convert(input ec_time_t t, input int delay, input int hold,
                         input sys_time_t exp, input string name);
    sys_time_t got;
    send_ec_time(t, hold);
    take_sys_time(delay, got);
    check_sys_time(got, exp, name);
  endtask

  // Second request raised while the first result waits for sys_ack
  task automatic back_pressure(input ec_time_t first, input ec_time_t second);
    sys_time_t held;
    sys_time_t got;
    send_ec_time(first, 0);
    while (!sys_req) @(negedge CLK);
    held = sys_time;
    check_sys_time(held, expected_sys_time(first), "back-pressure first result");
    ec_time = second;
    ec_req = 1'b1;
    repeat (50) begin
      @(negedge CLK);
      check_level(sys_req, 1'b1, "sys_req held under back-pressure");
      check_sys_time(sys_time, held, "sys_time held under back-pressure");
      check_level(ec_ack, 1'b0, "ec_ack quiet while output pending");
    end
    sys_ack = 1'b1;
    @(negedge CLK);
    check_level(sys_req, 1'b0, "sys_req released after sys_ack");
    check_level(ec_ack, 1'b0, "ec_ack quiet while sys_ack high");
    sys_ack = 1'b0;
    @(negedge CLK);
    check_level(ec_ack, 1'b0, "ec_ack quiet until downstream closes");
    while (!ec_ack) @(negedge CLK);
    ec_req = 1'b0;
    while (ec_ack) @(negedge CLK);
    take_sys_time(0, got);
    check_sys_time(got, expected_sys_time(second), "back-pressure second result");
  endtask

  initial begin
    #(timeout_ns);
    $display("Simulation timed out waiting for a handshake");
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    logic [63:0] r;
    logic [63:0] d;
    lfsr_q = 32'h4f4245c7;
    rst_n = 1'b0;
    ec_req = 1'b0;
    ec_time = '0;
    sys_ack = 1'b0;

    repeat (5) begin
      @(negedge CLK);
      check_level(ec_ack, 1'b0, "ec_ack during reset");
      check_level(sys_req, 1'b0, "sys_req during reset");
      check_sys_time(sys_time, '0, "sys_time during reset");
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge CLK);
      check_level(ec_ack, 1'b0, "ec_ack after reset");
      check_level(sys_req, 1'b0, "sys_req after reset");
      check_sys_time(sys_time, '0, "sys_time after reset");
    end

    convert(64'd0, 0, 0, 61'd0, "ec_time 0");
    convert(64'd31249, 0, 0, 61'd0, "ec_time 31249");
    convert(64'd31250, 0, 0, 61'd320, "ec_time 31250");
    convert(64'd62499, 0, 0, 61'd320, "ec_time 62499");
    convert(64'd31250 * 64'd1000 + 64'd7, 0, 0, 61'd320000, "ec_time 31250007");
    convert('1, 1, 0, expected_sys_time('1), "maximum ec_time");

    back_pressure(64'd31250 * 64'd77 + 64'd5, 64'd9876543210);

    convert(64'd123456789, 2, 3, expected_sys_time(64'd123456789), "four-phase order");

    for (int i = 0; i < 30; i++) begin
      draw_bits(64, r);
      draw_bits(3, d); // sys_ack delay 0 to 7
      convert(r, int'(d), 0, expected_sys_time(r), $sformatf("random sweep %0d", i));
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: rtl/ec_time_converter_top.sv
`timescale 1ns/100ps

module ec_time_converter_top (
  input logic CLK,
  input logic rst_n,
  input logic ec_req,
  output logic ec_ack,
  input ec_time_pkg::ec_time_t ec_time,
  output logic sys_req,
  input logic sys_ack,
  output ec_time_pkg::sys_time_t sys_time
);
  import ec_time_pkg::*;

  // EC time in, lap count out
  req_ack_if #(
    .req_t(ec_time_t),
    .resp_t(lap_t)
  ) div_ch ();

  // Lap count in, system time out
  req_ack_if #(
    .req_t(lap_t),
    .resp_t(sys_time_t)
  ) scale_ch ();

  ec_time_to_sys_time u_ec_time_to_sys_time (
    .CLK(CLK),
    .rst_n(rst_n),
    .ec_req(ec_req),
    .ec_ack(ec_ack),
    .ec_time(ec_time),
    .sys_req(sys_req),
    .sys_ack(sys_ack),
    .sys_time(sys_time),
    .div(div_ch.client),
    .scale(scale_ch.client)
  );

  lap_divider u_lap_divider (
    .CLK(CLK),
    .rst_n(rst_n),
    .ch(div_ch.server)
  );

  lap_scaler u_lap_scaler (
    .CLK(CLK),
    .rst_n(rst_n),
    .ch(scale_ch.server)
  );

endmodule

// File: rtl/ec_time_to_sys_time.sv
`timescale 1ns/100ps

module ec_time_to_sys_time (
  input logic CLK,
  input logic rst_n,
  input logic ec_req,
  output logic ec_ack,
  input ec_time_pkg::ec_time_t ec_time,
  output logic sys_req,
  input logic sys_ack,
  output ec_time_pkg::sys_time_t sys_time,
  req_ack_if.client div,
  req_ack_if.client scale
);
  import ec_time_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_up_ack,
    st_divide,
    st_scale,
    st_out_req,
    st_out_rel
  } state_t;

  state_t state_q;
  logic ec_ack_q;
  logic sys_req_q;
  logic div_req_q;
  logic scale_req_q;
  logic issued_q; // Internal request already raised in this state

  ec_time_t ec_time_q;
  lap_t lap_q;
  sys_time_t sys_time_q;

  assign ec_ack = ec_ack_q;
  assign sys_req = sys_req_q;
  assign sys_time = sys_time_q;

  assign div.req = div_req_q;
  assign div.req_data = ec_time_q;
  assign scale.req = scale_req_q;
  assign scale.req_data = lap_q;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state_q <= st_idle;
      ec_ack_q <= 1'b0;
      sys_req_q <= 1'b0;
      div_req_q <= 1'b0;
      scale_req_q <= 1'b0;
      issued_q <= 1'b0;
      sys_time_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (ec_req) begin
            state_q <= st_up_ack;
          end
        end
        st_up_ack: begin
          if (!ec_ack_q) begin
            ec_ack_q <= 1'b1; // Value latched on the previous edge
          end else if (!ec_req) begin
            ec_ack_q <= 1'b0;
            state_q <= st_divide;
          end
        end
        st_divide: begin
          if (!issued_q) begin
            div_req_q <= 1'b1;
            issued_q <= 1'b1;
          end else if (div_req_q && div.ack) begin
            div_req_q <= 1'b0;
          end else if (!div_req_q && !div.ack) begin
            issued_q <= 1'b0;
            state_q <= st_scale;
          end
        end
        st_scale: begin
          if (!issued_q) begin
            scale_req_q <= 1'b1;
            issued_q <= 1'b1;
          end else if (scale_req_q && scale.ack) begin
            sys_time_q <= scale.resp_data;
            scale_req_q <= 1'b0;
          end else if (!scale_req_q && !scale.ack) begin
            issued_q <= 1'b0;
            sys_req_q <= 1'b1;
            state_q <= st_out_req;
          end
        end
        st_out_req: begin
          if (sys_ack) begin
            sys_req_q <= 1'b0;
            state_q <= st_out_rel;
          end
        end
        st_out_rel: begin
          if (!sys_ack) begin
            state_q <= st_idle; // Downstream closed, ready for next timestamp
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge CLK) begin
    if (state_q == st_idle && ec_req) begin
      ec_time_q <= ec_time;
    end
    if (state_q == st_divide && div_req_q && div.ack) begin
      lap_q <= div.resp_data;
    end
  end

endmodule

// File: rtl/lap_scaler.sv
`timescale 1ns/100ps
`include "ec_time_params.svh"

module lap_scaler (
  input logic CLK,
  input logic rst_n,
  req_ack_if.server ch
);
  import ec_time_pkg::*;

  localparam int sum_w = `SYS_TIME_W - `LAP_SCALE_SHIFT;

  logic [1:0] req_dly_q;
  logic ack_q;
  lap_t lap;
  logic [sum_w-1:0] sum_q;
  sys_time_t prod_q;

  assign lap = ch.req_data;
  assign ch.ack = ack_q;
  assign ch.resp_data = prod_q;

  // Request delay line, flushed as soon as req drops
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      req_dly_q <= 2'b00;
      ack_q <= 1'b0;
    end else begin
      req_dly_q <= ch.req ? {req_dly_q[0], 1'b1} : 2'b00;
      ack_q <= ch.req & req_dly_q[1];
    end
  end

  // Stage one, lap times 5
  always_ff @(posedge CLK) begin
    if (ch.req) begin
      sum_q <= sum_w'(lap) + (sum_w'(lap) << 2);
    end
  end

  // Stage two, times 64
  always_ff @(posedge CLK) begin
    if (req_dly_q[0]) begin
      prod_q <= sys_time_t'(sum_q) << `LAP_SCALE_SHIFT;
    end
  end

endmodule

// File: rtl/lap_divider.sv
`timescale 1ns/100ps
`include "ec_time_params.svh"

module lap_divider (
  input logic CLK,
  input logic rst_n,
  req_ack_if.server ch
);
  import ec_time_pkg::*;

  localparam int steps = `EC_TIME_W;
  localparam int cnt_w = $clog2(steps);

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_run,
    st_done
  } state_t;

  state_t state_q;
  logic [cnt_w-1:0] cnt_q;
  logic ack_q;

  ec_time_t dvd_q; // Dividend bits still to shift in
  logic [16:0] rem_q; // Trial value, partial remainder plus next bit
  lap_t quot_q;
  logic ge;
  logic [15:0] rest;

  // One restoring step
  assign ge = rem_q >= 17'(`LAP_DIVISOR);
  assign rest = ge ? 16'(rem_q - 17'(`LAP_DIVISOR)) : rem_q[15:0];

  assign ch.ack = ack_q;
  assign ch.resp_data = quot_q;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state_q <= st_idle;
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (ch.req) begin
            state_q <= st_load;
          end
        end
        st_load: begin
          cnt_q <= '0;
          state_q <= st_run;
        end
        st_run: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == cnt_w'(steps - 1)) begin
            ack_q <= 1'b1; // Last quotient bit lands on this edge
            state_q <= st_done;
          end
        end
        st_done: begin
          if (!ch.req) begin
            ack_q <= 1'b0;
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state_q == st_load) begin
      rem_q <= {16'b0, ch.req_data[`EC_TIME_W-1]};
      dvd_q <= {ch.req_data[`EC_TIME_W-2:0], 1'b0};
    end else if (state_q == st_run) begin
      rem_q <= {rest, dvd_q[`EC_TIME_W-1]};
      dvd_q <= {dvd_q[`EC_TIME_W-2:0], 1'b0};
      quot_q <= {quot_q[`LAP_W-2:0], ge}; // Upper quotient bits fall off
    end
  end

endmodule

// File: rtl/req_ack_if.sv
`timescale 1ns/100ps

// Four-phase req/ack channel between a client and a server.
// The client holds req_data while req is high, and the server holds
// resp_data from the rise of ack until ack falls again.
interface req_ack_if #(
  parameter type req_t = logic,
  parameter type resp_t = logic
);

  logic req;
  logic ack;
  req_t req_data;
  resp_t resp_data;

  modport client (
    output req,
    output req_data,
    input ack,
    input resp_data
  );

  modport server (
    input req,
    input req_data,
    output ack,
    output resp_data
  );

endinterface

// File: rtl/ec_time_pkg.sv
`include "ec_time_params.svh"

package ec_time_pkg;

  // Raw timestamp in EC clock ticks
  typedef logic [`EC_TIME_W-1:0] ec_time_t;

  // Whole laps elapsed, remainder dropped
  typedef logic [`LAP_W-1:0] lap_t;

  // Timestamp in system time units
  typedef logic [`SYS_TIME_W-1:0] sys_time_t;

endpackage

// File: rtl/ec_time_params.svh
`ifndef EC_TIME_PARAMS_SVH
`define EC_TIME_PARAMS_SVH

// EC tick count width
`define EC_TIME_W 64

// Whole-lap count width, 50 bits needed plus one spare
`define LAP_W 51

// System time width
`define SYS_TIME_W 61

// EC ticks per lap
`define LAP_DIVISOR 16'd31250

// Shift after the times-5 step, giving a scale of 320
`define LAP_SCALE_SHIFT 6

`endif
